// File: vlog.f
common/uart_frame_pkg.sv
common/uart_cmd_pkg.sv
uart_tx/uart_tx_frame.sv
uart_rx/uart_rx_frame.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_cmd_bridge.sv
sim/uart_dev_model.sv
sim/uart_cmd_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UART command bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module uart_cmd_tb -f vlog.f -o uart_cmd_tb

./obj_dir/uart_cmd_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim: failure reported in sim.log"
  exit 1
fi

echo "run_sim: done"
exit 0

// File: sim/uart_cmd_tb.sv
`timescale 1ns/100ps

module uart_cmd_tb
  import uart_frame_pkg::*, uart_cmd_pkg::*;
();

  localparam int WRITE_LATENCY = 1 + (2 * FRAME_BITS + GAP_BITS) * CLKS_PER_BIT;
  localparam int WRITE_LIMIT   = 2 * WRITE_LATENCY;
  localparam int READ_LIMIT    = (2 * FRAME_BITS + RX_TIMEOUT_BITS + 8) * CLKS_PER_BIT;
  localparam int RDY_LIMIT     = 50;
  localparam int NUM_WORDS     = 6;
  localparam logic [6:0] PARITY_ADDR = 7'h15;
  localparam logic [6:0] STOP_ADDR   = 7'h2a;
  localparam logic [6:0] SILENT_ADDR = 7'h4c;

  logic                 clk;
  logic                 rst_n;
  logic [CMD_WIDTH-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 read_vld;
  logic [DATA_BITS-1:0] read_data;
  rd_status_t           read_status;
  logic                 read_ready;
  logic                 tx;
  logic                 rx;
  int                   errors = 0;
  int                   dev_errors;
  bit                   timed_out = 1'b0;
  logic [7:0]           shadow [0:127];
  // {addr, status, data}
  logic [16:0]          exp_q [$];
  logic [16:0]          got_q [$];

  uart_cmd_bridge UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_status (read_status),
    .read_ready  (read_ready),
    .tx          (tx),
    .rx          (rx)
  );

  uart_dev_model u_dev (
    .clk               (clk),
    .rst_n             (rst_n),
    .line_in           (tx),
    .line_out          (rx),
    .parity_fault_addr (PARITY_ADDR),
    .stop_fault_addr   (STOP_ADDR),
    .silent_addr       (SILENT_ADDR),
    .dev_errors        (dev_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference and checking

  function automatic logic [9:0] expected_read(input logic [6:0] addr);
    if (addr == SILENT_ADDR)
      return {RD_TIMEOUT, 8'h00};
    else if (addr == STOP_ADDR)
      return {RD_FRAME_ERR, shadow[addr]};
    else if (addr == PARITY_ADDR)
      return {RD_PARITY_ERR, shadow[addr]};
    return {RD_OK, shadow[addr]};
  endfunction

  task automatic check_val(input string what, input int got, input int exp);
    if (got != exp)
    begin
      errors++;
      $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("timeout at %0t ns: %s", $time, what);
  endtask

  always @(negedge clk)
  begin
    logic [16:0] exp_word;
    logic [16:0] got_word;
    while (got_q.size() > 0 && exp_q.size() > 0)
    begin
      got_word = got_q.pop_front();
      exp_word = exp_q.pop_front();
      check_val($sformatf("read data at %02h", exp_word[16:10]), got_word[7:0], exp_word[7:0]);
      check_val($sformatf("read status at %02h", exp_word[16:10]), got_word[9:8],
                exp_word[9:8]);
    end
  end

  //////////////////////////////////////////////////
  // host side tasks entered on a falling edge

  task automatic issue_cmd(input logic [CMD_WIDTH-1:0] word, output bit ok);
    int cnt;
    cnt = 0;
    while (!cmd_rdy && cnt < RDY_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    ok = cmd_rdy;
    if (!ok)
    begin
      report_timeout("cmd_rdy stayed low before a new command");
      return;
    end
    cmd_in  = word;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_val("cmd_rdy after accept", cmd_rdy, 0);
  endtask

  task automatic do_write(input logic [6:0] addr, input logic [7:0] data);
    bit ok;
    int cycles;
    if (timed_out)
      return;
    issue_cmd({1'b1, addr, data}, ok);
    if (!ok)
      return;
    cycles = 0;
    while (!cmd_rdy && cycles < WRITE_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_rdy)
    begin
      report_timeout("write never returned cmd_rdy");
      return;
    end
    check_val($sformatf("write latency at %02h", addr), cycles, WRITE_LATENCY);
    shadow[addr] = data;
  endtask

  task automatic do_read(input logic [6:0] addr);
    bit         ok;
    int         cnt;
    int         span;
    logic [7:0] held_data;
    rd_status_t held_status;
    if (timed_out)
      return;
    exp_q.push_back({addr, expected_read(addr)});
    issue_cmd({1'b0, addr, 8'h00}, ok);
    if (!ok)
      return;
    cnt = 0;
    while (!read_vld && cnt < READ_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    if (!read_vld)
    begin
      report_timeout("read_vld never rose");
      return;
    end
    held_data   = read_data;
    held_status = read_status;
    // host stalls for a while
    span = $urandom_range(0, 12);
    repeat (span)
    begin
      @(negedge clk);
      check_val("read_vld during stall", read_vld, 1);
      check_val("read_data during stall", read_data, held_data);
      check_val("read_status during stall", read_status, held_status);
      check_val("cmd_rdy during stall", cmd_rdy, 0);
    end
    read_ready = 1'b1;
    got_q.push_back({addr, read_status, read_data});
    @(negedge clk);
    read_ready = 1'b0;
    check_val("read_vld after transfer", read_vld, 0);
    check_val("cmd_rdy after transfer", cmd_rdy, 1);
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [6:0] addrs [NUM_WORDS];
    void'($urandom(16));
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    read_ready = 1'b0;
    for (int i = 0; i < 128; i++)
    begin
      shadow[i] = {i[6:0], i[6]} ^ 8'h5a;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_val("cmd_rdy after reset", cmd_rdy, 1);
    check_val("read_vld after reset", read_vld, 0);
    check_val("tx after reset", tx, 1);

    for (int i = 0; i < NUM_WORDS; i++)
    begin
      addrs[i] = 7'($urandom_range(0, 127));
      do_write(addrs[i], 8'($urandom));
    end
    do_write(PARITY_ADDR, 8'hc3);
    do_write(STOP_ADDR, 8'h3c);
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      do_read(addrs[i]);
    end
    do_read(PARITY_ADDR);
    do_read(STOP_ADDR);
    do_read(SILENT_ADDR);
    // bridge must recover after a timeout
    do_read(addrs[0]);

    repeat (4) @(negedge clk);
    $display("errors: %0d check, %0d device model, timeout %0d", errors, dev_errors,
             timed_out);
    if (errors == 0 && dev_errors == 0 && !timed_out)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: sim/uart_dev_model.sv
`timescale 1ns/100ps

module uart_dev_model
  import uart_frame_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       line_in,
  output logic       line_out,
  input  logic [6:0] parity_fault_addr,
  input  logic [6:0] stop_fault_addr,
  input  logic [6:0] silent_addr,
  output int         dev_errors
);

  // reply start, in bit times after the header stop sample
  localparam int TURN_BITS = 2;

  logic [7:0] mem [0:127];
  int         cyc = 0;

  initial
  begin
    line_out   = 1'b1;
    dev_errors = 0;
    for (int a = 0; a < 128; a++)
    begin
      mem[a] = {a[6:0], a[6]} ^ 8'h5a;
    end
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////
  // line receive and transmit

  // entered at the first low sample of a start bit
  task automatic recv_frame(output logic [7:0] data, output logic real_start);
    logic par;
    logic stp;
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    real_start = !line_in;
    for (int i = 0; i < DATA_BITS; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = line_in;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = line_in;
    repeat (CLKS_PER_BIT) @(negedge clk);
    stp = line_in;
    if (real_start && (par != ^data))
    begin
      dev_errors++;
      $display("ERROR at %0t ns: device model got bad parity on byte %02h", $time, data);
    end
    if (real_start && !stp)
    begin
      dev_errors++;
      $display("ERROR at %0t ns: device model got a low stop bit on byte %02h", $time, data);
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_par, input logic bad_stop);
    logic [FRAME_BITS-1:0] bits;
    bits = {!bad_stop, (^data) ^ bad_par, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      line_out = bits[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    line_out = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // command handling

  task automatic serve_command();
    logic [7:0] hdr;
    logic [7:0] data;
    logic       ok;
    int         t0;
    int         idle;
    t0 = cyc;
    recv_frame(hdr, ok);
    if (!ok)
    begin
      return;
    end
    if (hdr[7])
    begin
      idle = 0;
      while (line_in && idle < (GAP_BITS + 4) * CLKS_PER_BIT)
      begin
        @(negedge clk);
        idle++;
      end
      if (line_in)
      begin
        dev_errors++;
        $display("device model: write data frame never started at %0t ns", $time);
        return;
      end
      if (cyc - t0 - FRAME_BITS * CLKS_PER_BIT != GAP_BITS * CLKS_PER_BIT)
      begin
        dev_errors++;
        $display("ERROR at %0t ns: device model saw a write gap of %0d cycles", $time,
                 cyc - t0 - FRAME_BITS * CLKS_PER_BIT);
      end
      recv_frame(data, ok);
      mem[hdr[6:0]] = data;
    end
    else if (hdr[6:0] != silent_addr)
    begin
      repeat (TURN_BITS * CLKS_PER_BIT) @(negedge clk);
      send_frame(mem[hdr[6:0]], hdr[6:0] == parity_fault_addr, hdr[6:0] == stop_fault_addr);
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n && !line_in)
    begin
      serve_command();
    end
  end

endmodule

// File: verilog/uart_cmd_bridge.sv
`timescale 1ns/100ps

module uart_cmd_bridge
  import uart_frame_pkg::*, uart_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 read_vld,
  output logic [DATA_BITS-1:0] read_data,
  output rd_status_t           read_status,
  input  logic                 read_ready,
  output logic                 tx,
  input  logic                 rx
);

  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_start;
  logic                 tx_done;
  logic                 rx_en;
  logic                 rx_busy;
  logic                 rx_valid;
  logic [DATA_BITS-1:0] rx_byte;
  logic                 rx_parity_err;
  logic                 rx_frame_err;

  uart_cmd_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .read_vld      (read_vld),
    .read_data     (read_data),
    .read_status   (read_status),
    .read_ready    (read_ready),
    .tx_byte       (tx_byte),
    .tx_start      (tx_start),
    .tx_done       (tx_done),
    .rx_en         (rx_en),
    .rx_busy       (rx_busy),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx_frame u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_en         (rx_en),
    .rx            (rx),
    .rx_busy       (rx_busy),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

// File: verilog/uart_cmd_ctrl.sv
`timescale 1ns/100ps

module uart_cmd_ctrl
  import uart_frame_pkg::*, uart_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 read_vld,
  output logic [DATA_BITS-1:0] read_data,
  output rd_status_t           read_status,
  input  logic                 read_ready,
  output logic [DATA_BITS-1:0] tx_byte,
  output logic                 tx_start,
  input  logic                 tx_done,
  output logic                 rx_en,
  input  logic                 rx_busy,
  input  logic                 rx_valid,
  input  logic [DATA_BITS-1:0] rx_byte,
  input  logic                 rx_parity_err,
  input  logic                 rx_frame_err
);

  localparam int GAP_CYCLES = GAP_BITS * CLKS_PER_BIT;
  localparam int TMO_CYCLES = RX_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int GAP_W = $clog2(GAP_CYCLES);
  localparam int TMO_W = $clog2(TMO_CYCLES);
  // tx_start is registered, so leave the gap one cycle early
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYCLES - 2);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(TMO_CYCLES - 1);

  ctrl_state_t          state;
  cmd_op_t              cmd_op;
  logic [DATA_BITS-1:0] wr_data;
  logic [GAP_W-1:0]     gap_cnt;
  logic [TMO_W-1:0]     tmo_cnt;
  logic                 cmd_fire;
  logic                 rd_fire;
  logic                 gap_end;
  logic                 tmo_expire;
  rd_status_t           rx_status;

  assign cmd_rdy    = (state == IDLE);
  assign read_vld   = (state == RD_HOLD);
  assign rx_en      = (state == RD_WAIT);
  assign cmd_fire   = cmd_vld && cmd_rdy;
  assign rd_fire    = read_vld && read_ready;
  assign gap_end    = (state == WR_GAP) && (gap_cnt == GAP_LAST);
  assign tmo_expire = (tmo_cnt == TMO_LAST) && !rx_busy;

  // stop error first
  assign rx_status = rx_frame_err  ? RD_FRAME_ERR  :
                     rx_parity_err ? RD_PARITY_ERR : RD_OK;

  //////////////////////////////////////////////////
  // command FSM

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        IDLE:
        begin
          if (cmd_fire)
          begin
            state    <= SEND_HDR;
            tx_start <= 1'b1;
          end
        end
        SEND_HDR:
        begin
          gap_cnt <= '0;
          tmo_cnt <= '0;
          if (tx_done)
          begin
            state <= (cmd_op == OP_WRITE) ? WR_GAP : RD_WAIT;
          end
        end
        WR_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_end)
          begin
            state    <= SEND_DATA;
            tx_start <= 1'b1;
          end
        end
        SEND_DATA:
        begin
          if (tx_done)
          begin
            state <= IDLE;
          end
        end
        RD_WAIT:
        begin
          // frozen once the reply start bit is confirmed
          if (!rx_busy)
          begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
          if (rx_valid || tmo_expire)
          begin
            state <= RD_HOLD;
          end
        end
        RD_HOLD:
        begin
          if (rd_fire)
          begin
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // command capture and read result

  always_ff @(posedge clk)
  begin
    if (cmd_fire)
    begin
      cmd_op  <= cmd_op_t'(cmd_in[CMD_RW_BIT]);
      wr_data <= cmd_in[DATA_BITS-1:0];
      // header is {rw, addr}
      tx_byte <= {cmd_in[CMD_RW_BIT], cmd_in[CMD_RW_BIT-1 -: ADDR_WIDTH]};
    end
    else if (gap_end)
    begin
      tx_byte <= wr_data;
    end
    if (state == RD_WAIT)
    begin
      if (rx_valid)
      begin
        read_data   <= rx_byte;
        read_status <= rx_status;
      end
      else if (tmo_expire)
      begin
        read_data   <= '0;
        read_status <= RD_TIMEOUT;
      end
    end
  end

  a_tx_start_entry: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> (state inside {SEND_HDR, SEND_DATA}) && (state != $past(state))
  ) else $error("tx_start outside a send state entry");

  // result held until the host takes it
  a_read_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld && !read_ready |=>
      read_vld && !cmd_rdy && $stable(read_data) && $stable(read_status)
  ) else $error("read result changed before transfer");

endmodule

// File: uart_rx/uart_rx_frame.sv
`timescale 1ns/100ps

module uart_rx_frame
  import uart_frame_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx_en,
  input  logic                 rx,
  output logic                 rx_busy,
  output logic                 rx_valid,
  output logic [DATA_BITS-1:0] rx_byte,
  output logic                 rx_parity_err,
  output logic                 rx_frame_err
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(FRAME_BITS);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] PAR_IDX   = IDX_W'(DATA_BITS);
  localparam logic [IDX_W-1:0] STOP_IDX  = IDX_W'(FRAME_BITS - 2);

  typedef enum logic [1:0] {
    RX_HUNT,
    RX_START,
    RX_DATA
  } rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 fall;
  logic [CNT_W-1:0]     clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  logic                 sample;
  logic [DATA_BITS-1:0] shift_reg;
  logic                 par_bit;

  //////////////////////////////////////////////////
  // synchronizer and edge detect

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev && !rx_sync;
  assign sample  = (state == RX_DATA) && (clk_cnt == BIT_LAST);
  assign rx_busy = (state == RX_DATA);

  //////////////////////////////////////////////////
  // frame FSM

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_HUNT;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state)
        RX_HUNT:
        begin
          clk_cnt <= '0;
          if (rx_en && fall)
          begin
            state <= RX_START;
          end
        end
        RX_START:
        begin
          if (!rx_en)
          begin
            state <= RX_HUNT;
          end
          else if (clk_cnt == HALF_LAST)
          begin
            // mid start bit, high means a glitch
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_HUNT : RX_DATA;
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA:
        begin
          if (clk_cnt == BIT_LAST)
          begin
            clk_cnt <= '0;
            if (bit_idx == STOP_IDX)
            begin
              state    <= RX_HUNT;
              rx_valid <= 1'b1;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= RX_HUNT;
        end
      endcase
    end
  end

  // data in lsb first, then parity, then stop
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx < PAR_IDX)
      begin
        shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
      end
      else if (bit_idx == PAR_IDX)
      begin
        par_bit <= rx_sync;
      end
      else
      begin
        rx_byte       <= shift_reg;
        rx_parity_err <= (par_bit != ^shift_reg);
        rx_frame_err  <= !rx_sync;
      end
    end
  end

  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid
  ) else $error("rx_valid longer than one cycle");

endmodule

// File: uart_tx/uart_tx_frame.sv
`timescale 1ns/100ps

module uart_tx_frame
  import uart_frame_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [DATA_BITS-1:0] tx_byte,
  input  logic                 tx_start,
  output logic                 tx_done,
  output logic                 tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(FRAME_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(FRAME_BITS - 1);

  logic                  busy;
  logic [CNT_W-1:0]      clk_cnt;
  logic [IDX_W-1:0]      bit_idx;
  // bits still to go after the start bit
  logic [FRAME_BITS-2:0] shift_reg;
  logic                  bit_end;

  assign bit_end = busy && (clk_cnt == BIT_LAST);

  // last cycle of the stop bit
  assign tx_done = bit_end && (bit_idx == STOP_IDX);

  //////////////////////////////////////////////////
  // bit timing and line driver

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (tx_start)
    begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (bit_idx == STOP_IDX)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shift_reg[0];
      end
    end
    else if (busy)
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // stop, even parity, data lsb first
  always_ff @(posedge clk)
  begin
    if (tx_start)
    begin
      shift_reg <= {1'b1, ^tx_byte, tx_byte};
    end
    else if (bit_end)
    begin
      shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};
    end
  end

  //////////////////////////////////////////////////
  // checks

  // controller must wait for tx_done
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !busy
  ) else $error("tx_start while a frame is in flight");

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  ) else $error("tx low while transmitter idle");

endmodule

// File: common/uart_cmd_pkg.sv
package uart_cmd_pkg;

  //////////////////////////////////////////////////
  // host command word

  // {rw, addr[6:0], wdata[7:0]}
  localparam int CMD_WIDTH = 16;

  // 1 = write, 0 = read
  localparam int CMD_RW_BIT = 15;

  // register address bits below the rw bit
  localparam int ADDR_WIDTH = 7;

  //////////////////////////////////////////////////
  // enums

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HDR,
    WR_GAP,
    SEND_DATA,
    RD_WAIT,
    RD_HOLD
  } ctrl_state_t;

  // stop error wins over parity error
  typedef enum logic [1:0] {
    RD_OK,
    RD_PARITY_ERR,
    RD_FRAME_ERR,
    RD_TIMEOUT
  } rd_status_t;

endpackage

// File: common/uart_frame_pkg.sv
package uart_frame_pkg;

  //////////////////////////////////////////////////
  // serial line timing

  // clocks per serial bit, kept short for simulation
  localparam int CLKS_PER_BIT = 16;

  //////////////////////////////////////////////////
  // frame layout

  // payload bits per frame
  localparam int DATA_BITS = 8;

  // start + data + even parity + stop
  localparam int FRAME_BITS = 11;

  //////////////////////////////////////////////////
  // spacing and timeouts, in bit times

  // idle line between header and data frame of a write
  localparam int GAP_BITS = 2;

  // header stop end to reply start bit
  localparam int RX_TIMEOUT_BITS = 20;

endpackage
